/* common/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath and register file
`define MIPS_XLEN         32
`define MIPS_NREGS        32
`define MIPS_REG_W        $clog2(`MIPS_NREGS)
`define MIPS_REG_V0       2
`define MIPS_REG_RA       31

// boot address
`define MIPS_RESET_VECTOR 32'hbfc00000

// instruction word fields
`define MIPS_OPCODE_W     6
`define MIPS_FUNCT_W      6
`define MIPS_SHAMT_W      5
`define MIPS_INDEX_W      26

// words per generated test program
`define MIPS_PROG_WORDS   64

`endif

/* common/mips_pkg.sv */
`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0]  word_t;
    typedef logic [`MIPS_REG_W-1:0] reg_idx_t;

    typedef enum logic {
        RUN    = 1'b0,
        HALTED = 1'b1
    } state_t;

    // primary opcodes
    typedef enum logic [`MIPS_OPCODE_W-1:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_t;

    // SPECIAL function codes
    typedef enum logic [`MIPS_FUNCT_W-1:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_JR   = 6'b001000,
        F_JALR = 6'b001001,
        F_ADDU = 6'b100001,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_ALWAYS, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_LTZ, BR_GEZ
    } br_cond_t;

    typedef enum logic [1:0] {
        JK_NONE, JK_REGION, JK_REG
    } jump_kind_t;

    typedef struct packed {
        reg_idx_t                 rs;
        reg_idx_t                 rt;
        reg_idx_t                 wr;
        alu_op_t                  alu_op;
        logic                     b_imm;
        logic                     var_shift;
        word_t                    imm;
        logic [`MIPS_SHAMT_W-1:0] shamt;
        logic                     reg_write;
        logic                     mem_to_reg;
        logic                     link;
        logic                     load;
        logic                     store;
        br_cond_t                 cond;
        jump_kind_t               jump_kind;
    } decoded_t;

    typedef struct packed {
        logic                     taken;
        jump_kind_t               kind;
        word_t                    target_reg;
        word_t                    offset;
        logic [`MIPS_INDEX_W-1:0] index;
    } br_req_t;

endpackage

/* src/mips_decoder.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_decoder import mips_pkg::*; (
    input  logic [`MIPS_XLEN-1:0] instr,
    output decoded_t              dec
);

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rd;
    word_t    imm_sext;
    word_t    imm_zext;

    assign opcode   = opcode_t'(instr[31:26]);
    assign funct    = funct_t'(instr[5:0]);
    assign rd       = instr[15:11];
    assign imm_sext = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};
    assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, instr[15:0]};

    always_comb begin
        // anything not matched below stays a no-op
        dec       = '0;
        dec.rs    = instr[25:21];
        dec.rt    = instr[20:16];
        dec.wr    = instr[20:16];
        dec.shamt = instr[10:6];
        dec.imm   = imm_sext;

        case (opcode)
            OP_SPECIAL: begin
                dec.wr        = rd;
                dec.reg_write = 1'b1;
                case (funct)
                    F_ADDU: dec.alu_op = ALU_ADD;
                    F_SUBU: dec.alu_op = ALU_SUB;
                    F_AND:  dec.alu_op = ALU_AND;
                    F_OR:   dec.alu_op = ALU_OR;
                    F_XOR:  dec.alu_op = ALU_XOR;
                    F_SLT:  dec.alu_op = ALU_SLT;
                    F_SLTU: dec.alu_op = ALU_SLTU;
                    F_SLL:  dec.alu_op = ALU_SLL;
                    F_SRL:  dec.alu_op = ALU_SRL;
                    F_SRA:  dec.alu_op = ALU_SRA;
                    F_SLLV: begin
                        dec.alu_op    = ALU_SLL;
                        dec.var_shift = 1'b1;
                    end
                    F_SRLV: begin
                        dec.alu_op    = ALU_SRL;
                        dec.var_shift = 1'b1;
                    end
                    F_SRAV: begin
                        dec.alu_op    = ALU_SRA;
                        dec.var_shift = 1'b1;
                    end
                    F_JR: begin
                        dec.reg_write = 1'b0;
                        dec.cond      = BR_ALWAYS;
                        dec.jump_kind = JK_REG;
                    end
                    F_JALR: begin
                        dec.link      = 1'b1;
                        dec.cond      = BR_ALWAYS;
                        dec.jump_kind = JK_REG;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                // rt selects the test, bit 4 asks for a link
                if (instr[19:17] == 3'b000) begin
                    dec.cond = instr[16] ? BR_GEZ : BR_LTZ;
                    if (instr[20]) begin
                        // link is written whether or not the branch is taken
                        dec.reg_write = 1'b1;
                        dec.link      = 1'b1;
                        dec.wr        = reg_idx_t'(`MIPS_REG_RA);
                    end
                end
            end
            OP_J: begin
                dec.cond      = BR_ALWAYS;
                dec.jump_kind = JK_REGION;
            end
            OP_JAL: begin
                dec.cond      = BR_ALWAYS;
                dec.jump_kind = JK_REGION;
                dec.reg_write = 1'b1;
                dec.link      = 1'b1;
                dec.wr        = reg_idx_t'(`MIPS_REG_RA);
            end
            OP_BEQ:  dec.cond = BR_EQ;
            OP_BNE:  dec.cond = BR_NE;
            OP_BLEZ: dec.cond = BR_LEZ;
            OP_BGTZ: dec.cond = BR_GTZ;
            OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                dec.b_imm     = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_op    = (opcode == OP_ADDIU) ? ALU_ADD :
                                (opcode == OP_SLTI)  ? ALU_SLT : ALU_SLTU;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.b_imm     = 1'b1;
                dec.reg_write = 1'b1;
                dec.imm       = imm_zext;
                dec.alu_op    = (opcode == OP_ANDI) ? ALU_AND :
                                (opcode == OP_ORI)  ? ALU_OR  :
                                (opcode == OP_XORI) ? ALU_XOR : ALU_LUI;
            end
            OP_LW: begin
                dec.b_imm      = 1'b1;
                dec.reg_write  = 1'b1;
                dec.mem_to_reg = 1'b1;
                dec.load       = 1'b1;
            end
            OP_SW: begin
                dec.b_imm = 1'b1;
                dec.store = 1'b1;
            end
            default: dec.reg_write = 1'b0;
        endcase
    end

endmodule

/* src/mips_regfile.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_regfile import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_addr,
    input  reg_idx_t rt_addr,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data,
    output word_t    v0
);

    word_t regs [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 never gets written, so it reads back as zero
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[`MIPS_REG_V0];

endmodule

/* src/mips_alu.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_alu import mips_pkg::*; (
    input  alu_op_t                  op,
    input  word_t                    a,
    input  word_t                    b,
    input  logic [`MIPS_SHAMT_W-1:0] shamt,
    input  br_cond_t                 cond,
    output word_t                    result,
    output logic                     taken
);

    logic a_neg;
    logic a_zero;

    assign a_neg  = a[`MIPS_XLEN-1];
    assign a_zero = (a == '0);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);
            // shifts work on the rt side
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = word_t'($signed(b) >>> shamt);
            ALU_LUI:  result = b << 16;
            default:  result = '0;
        endcase
    end

    // sign tests look at rs only
    always_comb begin
        case (cond)
            BR_ALWAYS: taken = 1'b1;
            BR_EQ:     taken = (a == b);
            BR_NE:     taken = (a != b);
            BR_GTZ:    taken = !a_neg && !a_zero;
            BR_LEZ:    taken = a_neg || a_zero;
            BR_LTZ:    taken = a_neg;
            BR_GEZ:    taken = !a_neg;
            default:   taken = 1'b0;
        endcase
    end

endmodule

/* src/mips_pc_unit.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_pc_unit import mips_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     enable,
    input  logic                     taken,
    input  jump_kind_t               jump_kind,
    input  word_t                    target_reg,
    input  word_t                    offset,
    input  logic [`MIPS_INDEX_W-1:0] index,
    output word_t                    pc,
    output logic                     retire,
    output logic                     active
);

    // low until the first reset
    state_t state = HALTED;
    logic   pending;
    word_t  pending_target;
    word_t  pc_plus4;
    word_t  target;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (jump_kind)
            JK_REG:    target = target_reg;
            JK_REGION: target = {pc_plus4[`MIPS_XLEN-1 -: 4], index, 2'b00};
            default:   target = pc_plus4 + {offset[`MIPS_XLEN-3:0], 2'b00};
        endcase
    end

    assign retire = (state == RUN) && enable && !reset && (pc != '0);
    assign active = (state == RUN);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `MIPS_RESET_VECTOR;
            state   <= RUN;
            pending <= 1'b0;
        end else if (state == RUN && enable) begin
            if (pc == '0) begin
                state <= HALTED;
            end else begin
                // delay slot retires here, then pc moves to the saved target
                pc      <= pending ? pending_target : pc_plus4;
                pending <= taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire && taken) begin
            pending_target <= target;
        end
    end

endmodule

/* src/mips_cpu_harvard.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_cpu_harvard import mips_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 active,
    output logic [`MIPS_XLEN-1:0] register_v0,

    input  logic                 clk_enable,

    // instruction bus, read combinationally
    output logic [`MIPS_XLEN-1:0] instr_address,
    input  logic [`MIPS_XLEN-1:0] instr_readdata,

    // data bus, combinational read and one-cycle write
    output logic [`MIPS_XLEN-1:0] data_address,
    output logic                 data_write,
    output logic                 data_read,
    output logic [`MIPS_XLEN-1:0] data_writedata,
    input  logic [`MIPS_XLEN-1:0] data_readdata
);

    decoded_t                 dec;
    br_req_t                  br_req;
    word_t                    rs_data;
    word_t                    rt_data;
    word_t                    alu_b;
    word_t                    alu_result;
    word_t                    wb_data;
    word_t                    pc;
    word_t                    pc_plus8;
    logic [`MIPS_SHAMT_W-1:0] alu_shamt;
    logic                     alu_taken;
    logic                     retire;

    mips_decoder i_decoder (
        .instr (instr_readdata),
        .dec   (dec)
    );

    mips_regfile i_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (dec.rs),
        .rt_addr (dec.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (dec.reg_write && retire),
        .wr_addr (dec.wr),
        .wr_data (wb_data),
        .v0      (register_v0)
    );

    assign alu_b     = dec.b_imm ? dec.imm : rt_data;
    assign alu_shamt = dec.var_shift ? rs_data[`MIPS_SHAMT_W-1:0] : dec.shamt;

    mips_alu i_alu (
        .op     (dec.alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (alu_shamt),
        .cond   (dec.cond),
        .result (alu_result),
        .taken  (alu_taken)
    );

    assign br_req.taken      = alu_taken;
    assign br_req.kind       = dec.jump_kind;
    assign br_req.target_reg = rs_data;
    assign br_req.offset     = dec.imm;
    assign br_req.index      = instr_readdata[`MIPS_INDEX_W-1:0];

    mips_pc_unit i_pc_unit (
        .clk        (clk),
        .reset      (reset),
        .enable     (clk_enable),
        .taken      (br_req.taken),
        .jump_kind  (br_req.kind),
        .target_reg (br_req.target_reg),
        .offset     (br_req.offset),
        .index      (br_req.index),
        .pc         (pc),
        .retire     (retire),
        .active     (active)
    );

    assign instr_address = pc;
    assign pc_plus8      = pc + 32'd8;

    // lw/sw address comes out of the alu adder, word aligned
    assign data_address   = {alu_result[`MIPS_XLEN-1:2], 2'b00};
    assign data_writedata = rt_data;
    assign data_read      = dec.load;
    assign data_write     = dec.store && retire;

    always_comb begin
        if (dec.link) begin
            wb_data = pc_plus8;
        end else if (dec.mem_to_reg) begin
            wb_data = data_readdata;
        end else begin
            wb_data = alu_result;
        end
    end

endmodule

/* test/mips_cpu_checker.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_cpu_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  clk_enable,
    input logic                  active,
    input logic [`MIPS_XLEN-1:0] instr_address,
    input logic                  data_write,
    input logic                  data_read
);

    int fail_count = 0;

    bus_exclusive: assert property (@(posedge clk) !(data_write && data_read))
        else begin
            fail_count = fail_count + 1;
            $error("data_write and data_read high in the same cycle");
        end

    no_store_when_idle: assert property (@(posedge clk) disable iff (reset)
        !active |-> !data_write)
        else begin
            fail_count = fail_count + 1;
            $error("data_write high while the core is not active");
        end

    // a stalled cycle must not move the pc
    pc_holds_on_stall: assert property (@(posedge clk) disable iff (reset)
        active && !clk_enable |=> $stable(instr_address))
        else begin
            fail_count = fail_count + 1;
            $error("instr_address changed across a cycle with clk_enable low");
        end

    halt_is_sticky: assert property (@(posedge clk) disable iff (reset)
        !active |=> !active)
        else begin
            fail_count = fail_count + 1;
            $error("active rose again without a reset");
        end

endmodule

bind mips_cpu_harvard mips_cpu_checker i_checker (.*);

/* test/mips_scoreboard.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_scoreboard (
    input logic        clk,
    input logic        reset,
    input logic        clk_enable,
    input logic        active,
    input logic [31:0] register_v0,
    input logic [31:0] instr_address,
    input logic [31:0] data_address,
    input logic        data_write,
    input logic        data_read,
    input logic [31:0] data_writedata
);

    localparam logic [31:0] DATA_BASE = 32'h10000000;
    localparam logic [31:0] RV        = `MIPS_RESET_VECTOR;

    // loaded by the testbench before each run
    logic [31:0] prog [`MIPS_PROG_WORDS];
    logic [31:0] dmem [256];

    logic [31:0] regs [`MIPS_NREGS];
    logic [31:0] pc;
    logic [31:0] pend_target;
    logic        pending;
    logic        running;
    logic        started = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic execute();
        logic [31:0] off;
        logic [31:0] instr;
        logic [31:0] rsv;
        logic [31:0] rtv;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] pc4;
        logic [31:0] tgt;
        logic [31:0] wval;
        logic [31:0] addr;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [4:0]  widx;
        logic        wen;
        logic        taken;
        logic        is_load;
        logic        is_store;
        off = pc - RV;
        instr = (off < 4 * `MIPS_PROG_WORDS) ? prog[off[7:2]] : 32'h0;
        op = instr[31:26];
        fn = instr[5:0];
        rt = instr[20:16];
        rd = instr[15:11];
        sh = instr[10:6];
        rsv = regs[instr[25:21]];
        rtv = regs[rt];
        se = {{16{instr[15]}}, instr[15:0]};
        ze = {16'h0, instr[15:0]};
        pc4 = pc + 32'd4;
        tgt = pc4 + (se << 2);
        wen = 1'b0;
        widx = rt;
        wval = '0;
        taken = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        case (op)
            6'h00: begin
                wen = 1'b1;
                widx = rd;
                case (fn)
                    6'h00: wval = rtv << sh;
                    6'h02: wval = rtv >> sh;
                    6'h03: wval = $signed(rtv) >>> sh;
                    6'h04: wval = rtv << rsv[4:0];
                    6'h06: wval = rtv >> rsv[4:0];
                    6'h07: wval = $signed(rtv) >>> rsv[4:0];
                    6'h08: begin
                        wen = 1'b0;
                        taken = 1'b1;
                        tgt = rsv;
                    end
                    6'h09: begin
                        taken = 1'b1;
                        tgt = rsv;
                        wval = pc + 32'd8;
                    end
                    6'h21: wval = rsv + rtv;
                    6'h23: wval = rsv - rtv;
                    6'h24: wval = rsv & rtv;
                    6'h25: wval = rsv | rtv;
                    6'h26: wval = rsv ^ rtv;
                    6'h2a: wval = {31'h0, $signed(rsv) < $signed(rtv)};
                    6'h2b: wval = {31'h0, rsv < rtv};
                    default: begin
                        wen = 1'b0;
                        other_errors++;
                        $display("model met an unknown function code at pc %h", pc);
                    end
                endcase
            end
            6'h01: begin
                taken = rt[0] ? !rsv[31] : rsv[31];
                if (rt[4]) begin
                    wen = 1'b1;
                    widx = 5'd`MIPS_REG_RA;
                    wval = pc + 32'd8;
                end
            end
            6'h02, 6'h03: begin
                taken = 1'b1;
                tgt = {pc4[31:28], instr[25:0], 2'b00};
                if (op[0]) begin
                    wen = 1'b1;
                    widx = 5'd`MIPS_REG_RA;
                    wval = pc + 32'd8;
                end
            end
            6'h04: taken = (rsv == rtv);
            6'h05: taken = (rsv != rtv);
            6'h06: taken = ($signed(rsv) <= 0);
            6'h07: taken = ($signed(rsv) > 0);
            6'h09: begin
                wen = 1'b1;
                wval = rsv + se;
            end
            6'h0a: begin
                wen = 1'b1;
                wval = {31'h0, $signed(rsv) < $signed(se)};
            end
            6'h0b: begin
                wen = 1'b1;
                wval = {31'h0, rsv < se};
            end
            6'h0c: begin
                wen = 1'b1;
                wval = rsv & ze;
            end
            6'h0d: begin
                wen = 1'b1;
                wval = rsv | ze;
            end
            6'h0e: begin
                wen = 1'b1;
                wval = rsv ^ ze;
            end
            6'h0f: begin
                wen = 1'b1;
                wval = {instr[15:0], 16'h0};
            end
            6'h23, 6'h2b: begin
                addr = (rsv + se) & ~32'h3;
                off = addr - DATA_BASE;
                is_load = !op[3];
                is_store = op[3];
                check_value("data_address", data_address, addr);
                if (off >= 32'd1024) begin
                    other_errors++;
                    $display("model access outside the data window at pc %h", pc);
                end else if (is_load) begin
                    wen = 1'b1;
                    wval = dmem[off[9:2]];
                end else begin
                    check_value("data_writedata", data_writedata, rtv);
                    dmem[off[9:2]] = rtv;
                end
            end
            default: begin
                other_errors++;
                $display("model met an unknown opcode at pc %h", pc);
            end
        endcase
        check_value("data_read", {31'h0, data_read}, {31'h0, is_load});
        check_value("data_write", {31'h0, data_write}, {31'h0, is_store});
        if (wen && widx != 5'd0) begin
            regs[widx] = wval;
        end
        // delay slot: the saved target applies one retirement later
        pc = pending ? pend_target : pc4;
        pending = taken;
        if (taken) begin
            pend_target = tgt;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pc = RV;
            running = 1'b1;
            pending = 1'b0;
            started = 1'b1;
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] = '0;
            end
        end else if (started) begin
            check_value("active", {31'h0, active}, {31'h0, running});
            check_value("instr_address", instr_address, pc);
            check_value("register_v0", register_v0, regs[`MIPS_REG_V0]);
            if (running && clk_enable && pc == '0) begin
                running = 1'b0;
                check_value("data_write", {31'h0, data_write}, 32'h0);
            end else if (running && clk_enable) begin
                execute();
            end else begin
                check_value("data_write", {31'h0, data_write}, 32'h0);
            end
        end
    end

endmodule

/* test/tb_mips_cpu.sv */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tb_mips_cpu;

    localparam logic [31:0] DATA_BASE = 32'h10000000;
    localparam logic [31:0] RV        = `MIPS_RESET_VECTOR;
    localparam int NPROG        = 8;
    localparam int RESET_CYCLES = 4;
    localparam int LIMIT_CYCLES = NPROG * `MIPS_PROG_WORDS * 8 + NPROG * (RESET_CYCLES + 6);

    logic        clk = 1'b0;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;
    logic        data_write;
    logic        data_read;
    logic [31:0] ioff;
    logic [31:0] doff;
    logic [31:0] lfsr;
    logic [31:0] salt;
    logic [31:0] prog [`MIPS_PROG_WORDS];
    logic [31:0] dmem [256];
    logic        reserved [`MIPS_PROG_WORDS];
    int          total_errors;

    always #2 clk = ~clk;

    mips_cpu_harvard i_dut (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    mips_scoreboard i_sb (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata)
    );

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e3779b1) ^ salt;
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh,
                                           input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    assign ioff = instr_address - RV;
    assign doff = data_address - DATA_BASE;
    assign instr_readdata = (ioff < 4 * `MIPS_PROG_WORDS) ? prog[ioff[7:2]] : 32'h0;
    assign data_readdata  = (doff < 32'd1024) ? dmem[doff[9:2]] : fill_word(data_address);

    always @(posedge clk) begin
        if (data_write && doff < 32'd1024) begin
            dmem[doff[9:2]] <= data_writedata;
        end
    end

    task automatic load_program();
        logic [5:0]  r_fns [13];
        logic [5:0]  i_ops [7];
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] taddr;
        logic        delay_slot;
        int          i;
        int          t;
        int          kind;
        int          c;
        r_fns = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h21,
                  6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b};
        i_ops = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
        for (int k = 0; k < `MIPS_PROG_WORDS; k++) begin
            prog[k] = '0;
            reserved[k] = 1'b0;
        end
        // r1 holds the data window base for the whole program
        prog[0] = i_word(6'h0f, 5'd0, 5'd1, DATA_BASE[31:16]);
        i = 1;
        delay_slot = 1'b0;
        while (i < 30) begin
            kind = int'(take_bits(4));
            if (delay_slot || i > 27) begin
                kind = kind % 13;
            end
            delay_slot = 1'b0;
            rs = 5'(take_bits(5));
            rt = 5'(take_bits(5));
            rd = 5'(take_bits(5));
            // r1, r30 and r31 stay reserved so those picks go to r0
            if (rd == 5'd1 || rd >= 5'd30) begin
                rd = 5'd0;
            end
            if (kind < 8) begin
                c = int'(take_bits(4)) % 13;
                prog[i] = r_word(rs, rt, rd, (c < 3) ? 5'(take_bits(5)) : 5'd0, r_fns[c]);
            end else if (kind < 11) begin
                c = int'(take_bits(3)) % 7;
                prog[i] = i_word(i_ops[c], (c == 6) ? 5'd0 : rs, rd, 16'(take_bits(16)));
            end else if (kind < 13) begin
                prog[i] = i_word((kind == 11) ? 6'h23 : 6'h2b, 5'd1, (kind == 11) ? rd : rt,
                                 {6'h0, 8'(take_bits(8)), 2'b00});
            end else begin
                c = int'(take_bits(3));
                if (c >= 6 && (i > 25 || reserved[i+1] || reserved[i+2])) begin
                    c = c - 6;
                end
                if (c < 6) begin
                    t = i + 2 + int'(take_bits(2));
                end else begin
                    t = i + 4 + int'(take_bits(2));
                end
                if (t > 30) begin
                    t = 30;
                end
                reserved[t] = 1'b1;
                taddr = RV + 32'(4 * t);
                case (c)
                    0: prog[i] = i_word(6'h04, rs, rt, 16'(t - i - 1));
                    1: prog[i] = i_word(6'h05, rs, rt, 16'(t - i - 1));
                    2: prog[i] = i_word(rt[0] ? 6'h06 : 6'h07, rs, 5'd0, 16'(t - i - 1));
                    3: prog[i] = i_word(6'h01, rs, {rt[1], 3'b000, rt[0]}, 16'(t - i - 1));
                    4: prog[i] = {6'h02, taddr[27:2]};
                    5: prog[i] = {6'h03, taddr[27:2]};
                    default: begin
                        // r30 is kept for register jump targets
                        prog[i] = i_word(6'h0f, 5'd0, 5'd30, taddr[31:16]);
                        prog[i+1] = i_word(6'h0d, 5'd30, 5'd30, taddr[15:0]);
                        prog[i+2] = r_word(5'd30, 5'd0, (c == 6) ? 5'd0 : rd, 5'd0,
                                           (c == 6) ? 6'h08 : 6'h09);
                        i = i + 2;
                    end
                endcase
                delay_slot = 1'b1;
            end
            i++;
        end
        for (int k = 0; k < 32; k++) begin
            prog[30+k] = i_word(6'h2b, 5'd1, 5'(k), 16'(4 * k));
        end
        prog[62] = r_word(5'd0, 5'd0, 5'd0, 5'd0, 6'h08);
        prog[63] = 32'h0;
        salt = take_bits(32);
        for (int k = 0; k < `MIPS_PROG_WORDS; k++) begin
            i_sb.prog[k] = prog[k];
        end
        for (int k = 0; k < 256; k++) begin
            dmem[k] = fill_word(DATA_BASE + 32'(4 * k));
            i_sb.dmem[k] = dmem[k];
        end
    endtask

    initial begin
        lfsr = 32'h135add95;
        reset = 1'b1;
        clk_enable = 1'b0;
        for (int p = 0; p < NPROG; p++) begin
            reset = 1'b1;
            clk_enable = 1'b0;
            load_program();
            repeat (RESET_CYCLES) @(negedge clk);
            reset = 1'b0;
            do begin
                clk_enable = (take_bits(2) != 0);
                @(negedge clk);
            end while (active);
            // a few cycles after the halt
            repeat (3) begin
                clk_enable = (take_bits(2) != 0);
                @(negedge clk);
            end
        end
        total_errors = i_sb.value_errors + i_sb.other_errors + i_dut.i_checker.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion",
                 i_sb.value_errors, i_sb.other_errors, i_dut.i_checker.fail_count);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * 4);
        $display("watchdog expired, programs did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/mips_pkg.sv
src/mips_decoder.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_pc_unit.sv
src/mips_cpu_harvard.sv
test/mips_cpu_checker.sv
test/mips_scoreboard.sv
test/tb_mips_cpu.sv

/* Makefile */
TOP := tb_mips_cpu

all: run

build:
	verilator --binary --timing --assert -sv -f src.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing -sv -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
